// File: hw/bridge_pkg.sv
package bridge_pkg;

	// One character on the host channel
	typedef struct packed {
		logic       last;
		logic [7:0] data;
	} host_char_t;

	// First byte of a reply frame
	localparam logic [7:0] ACK_FLAG = 8'h41;
	localparam logic [7:0] NAK_FLAG = 8'h4E;

endpackage

// File: hw/mbus_pkg.sv
package mbus_pkg;

	// pend set means another word of the same message follows
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        pend;
	} mbus_tx_word_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic        pend;
		logic        bcast;
		logic        fail;
	} mbus_rx_word_t;

	// Transmit outcome with succ clear on failure
	typedef struct packed {
		logic succ;
	} tx_result_t;

endpackage

// File: hw/reqack_slice.sv
`timescale 1ns/10ps

module reqack_slice #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_req,
	output logic     in_ack,
	input  payload_t in_data,
	output logic     out_req,
	input  logic     out_ack,
	output payload_t out_data
);
	logic full;
	logic take;

	// Capture only into an empty buffer and after the previous ack has dropped
	assign take = in_req && !in_ack && !full;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_ack <= 1'b0;
			out_req <= 1'b0;
			full <= 1'b0;
		end else begin
			if (take)
				in_ack <= 1'b1;
			else if (in_ack && !in_req)
				in_ack <= 1'b0;

			if (take)
				full <= 1'b1;
			else if (out_req && out_ack)
				full <= 1'b0;

			// Next req waits for the receiver to release ack
			if (out_req && out_ack)
				out_req <= 1'b0;
			else if (full && !out_req && !out_ack)
				out_req <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			out_data <= in_data;
	end

endmodule

// File: hw/tx_frame_packer.sv
`timescale 1ns/10ps

module tx_frame_packer (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_req,
	output logic                    in_ack,
	input  bridge_pkg::host_char_t  in_char,
	output logic                    word_req,
	input  logic                    word_ack,
	output mbus_pkg::mbus_tx_word_t word,
	input  logic                    result_req,
	output logic                    result_ack,
	input  mbus_pkg::tx_result_t    result,
	output logic                    reply_req,
	input  logic                    reply_ack,
	output logic [7:0]              reply_eid,
	output logic                    reply_succ
);
	typedef enum logic [2:0] {S_EID, S_ADDR, S_DATA, S_WORD, S_RESULT, S_REPLY} state_t;

	state_t      state;
	logic [1:0]  byte_cnt;
	logic [31:0] addr_sr;
	logic [31:0] data_sr;
	logic        pend;
	logic        take;
	logic        take_result;

	// Host bytes are accepted only while parsing
	assign take = in_req && !in_ack &&
		(state == S_EID || state == S_ADDR || state == S_DATA);
	assign take_result = (state == S_RESULT) && result_req && !result_ack;

	assign word.addr = addr_sr;
	assign word.data = data_sr;
	assign word.pend = pend;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_EID;
			byte_cnt <= 2'd0;
			in_ack <= 1'b0;
			word_req <= 1'b0;
			result_ack <= 1'b0;
			reply_req <= 1'b0;
		end else begin
			if (take)
				in_ack <= 1'b1;
			else if (in_ack && !in_req)
				in_ack <= 1'b0;

			if (take_result)
				result_ack <= 1'b1;
			else if (result_ack && !result_req)
				result_ack <= 1'b0;

			case (state)
				S_EID: begin
					if (take)
						state <= S_ADDR;
				end
				S_ADDR, S_DATA: begin
					if (take) begin
						byte_cnt <= byte_cnt + 2'd1;
						// Fourth byte completes the address or a data word
						if (byte_cnt == 2'd3)
							state <= (state == S_ADDR) ? S_DATA : S_WORD;
					end
				end
				S_WORD: begin
					if (word_req && word_ack) begin
						word_req <= 1'b0;
						state <= pend ? S_DATA : S_RESULT;
					end else if (!word_req && !word_ack) begin
						word_req <= 1'b1;
					end
				end
				S_RESULT: begin
					if (take_result)
						state <= S_REPLY;
				end
				default: begin
					if (reply_req && reply_ack) begin
						reply_req <= 1'b0;
						state <= S_EID;
					end else if (!reply_req && !reply_ack) begin
						reply_req <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			case (state)
				S_EID: reply_eid <= in_char.data;
				S_ADDR: addr_sr <= {addr_sr[23:0], in_char.data};
				default: data_sr <= {data_sr[23:0], in_char.data};
			endcase
			if (state == S_DATA && byte_cnt == 2'd3)
				pend <= !in_char.last;
		end
		if (take_result)
			reply_succ <= result.succ;
	end

endmodule

// File: hw/rx_word_serializer.sv
`timescale 1ns/10ps

module rx_word_serializer #(
	parameter logic [7:0] RX_FLAG = 8'h62
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    word_req,
	output logic                    word_ack,
	input  mbus_pkg::mbus_rx_word_t word,
	output logic                    chr_req,
	input  logic                    chr_ack,
	output bridge_pkg::host_char_t  chr
);
	typedef enum logic [2:0] {S_IDLE, S_FLAG, S_SEQ, S_DATA, S_NEXT, S_STATUS} state_t;

	state_t                 state;
	logic [63:0]            sr;
	logic [2:0]             cnt;
	logic [1:0]             status;
	logic                   pend;
	logic [7:0]             seq;
	logic                   take;
	logic                   sending;
	logic                   send;
	logic                   done;
	bridge_pkg::host_char_t chr_next;

	assign take = word_req && !word_ack && (state == S_IDLE || state == S_NEXT);
	assign sending = state inside {S_FLAG, S_SEQ, S_DATA, S_STATUS};
	assign send = sending && !chr_req && !chr_ack;
	assign done = chr_req && chr_ack;

	always_comb begin
		chr_next.last = 1'b0;
		case (state)
			S_FLAG: chr_next.data = RX_FLAG;
			S_SEQ: chr_next.data = seq;
			S_STATUS: begin
				// bit 1 any fail, bit 0 any bcast
				chr_next.data = {6'd0, status};
				chr_next.last = 1'b1;
			end
			default: chr_next.data = sr[63:56];
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			word_ack <= 1'b0;
			chr_req <= 1'b0;
			cnt <= 3'd0;
			seq <= 8'd0;
		end else begin
			if (take)
				word_ack <= 1'b1;
			else if (word_ack && !word_req)
				word_ack <= 1'b0;

			if (send)
				chr_req <= 1'b1;
			else if (done)
				chr_req <= 1'b0;

			if (take) begin
				// First word sends address and data, chained words data only
				cnt <= (state == S_IDLE) ? 3'd7 : 3'd3;
				state <= (state == S_IDLE) ? S_FLAG : S_DATA;
			end else if (done) begin
				case (state)
					S_FLAG: state <= S_SEQ;
					S_SEQ: state <= S_DATA;
					S_DATA: begin
						cnt <= cnt - 3'd1;
						if (cnt == 3'd0)
							state <= pend ? S_NEXT : S_STATUS;
					end
					default: begin
						seq <= seq + 8'd1;
						state <= S_IDLE;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pend <= word.pend;
			if (state == S_IDLE) begin
				sr <= {word.addr, word.data};
				status <= {word.fail, word.bcast};
			end else begin
				sr <= {word.data, 32'd0};
				status <= status | {word.fail, word.bcast};
			end
		end else if (done && state == S_DATA) begin
			sr <= {sr[55:0], 8'd0};
		end
		if (send)
			chr <= chr_next;
	end

endmodule

// File: hw/reply_merger.sv
`timescale 1ns/10ps

module reply_merger (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   reply_req,
	output logic                   reply_ack,
	input  logic [7:0]             reply_eid,
	input  logic                   reply_succ,
	input  logic                   rx_req,
	output logic                   rx_ack,
	input  bridge_pkg::host_char_t rx_chr,
	output logic                   out_req,
	input  logic                   out_ack,
	output bridge_pkg::host_char_t out_chr
);
	logic                   rep_valid;
	logic                   rep_idx;
	logic [7:0]             eid_q;
	logic                   succ_q;
	logic                   busy;
	logic                   sel;
	logic                   prio;
	logic                   take_rep;
	logic                   can_send;
	logic                   load_rep;
	logic                   load_rx;
	bridge_pkg::host_char_t rep_chr;

	assign take_rep = reply_req && !reply_ack && !rep_valid;
	assign can_send = busy && !out_req && !out_ack;
	// sel 0 is the reply source, 1 the receive source
	assign load_rep = can_send && !sel && rep_valid;
	assign load_rx = can_send && sel && rx_req && !rx_ack;

	assign rep_chr.data = rep_idx ? eid_q :
		(succ_q ? bridge_pkg::ACK_FLAG : bridge_pkg::NAK_FLAG);
	assign rep_chr.last = rep_idx;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			reply_ack <= 1'b0;
			rx_ack <= 1'b0;
			out_req <= 1'b0;
			rep_valid <= 1'b0;
			rep_idx <= 1'b0;
			busy <= 1'b0;
			sel <= 1'b0;
			prio <= 1'b0;
		end else begin
			if (take_rep)
				reply_ack <= 1'b1;
			else if (reply_ack && !reply_req)
				reply_ack <= 1'b0;

			if (load_rx)
				rx_ack <= 1'b1;
			else if (rx_ack && !rx_req)
				rx_ack <= 1'b0;

			if (take_rep)
				rep_valid <= 1'b1;

			// Grant changes only between frames
			if (!busy) begin
				if (rep_valid && (!rx_req || !prio)) begin
					busy <= 1'b1;
					sel <= 1'b0;
				end else if (rx_req) begin
					busy <= 1'b1;
					sel <= 1'b1;
				end
			end

			if (load_rep || load_rx) begin
				out_req <= 1'b1;
			end else if (out_req && out_ack) begin
				out_req <= 1'b0;
				if (!sel) begin
					rep_idx <= !rep_idx;
					if (rep_idx)
						rep_valid <= 1'b0;
				end
				if (out_chr.last) begin
					busy <= 1'b0;
					prio <= !sel;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_rep) begin
			eid_q <= reply_eid;
			succ_q <= reply_succ;
		end
		if (load_rep)
			out_chr <= rep_chr;
		else if (load_rx)
			out_chr <= rx_chr;
	end

endmodule

// File: hw/mbus_bridge.sv
`timescale 1ns/10ps

module mbus_bridge #(
	parameter logic [7:0] RX_FLAG = 8'h62
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    host_in_req,
	output logic                    host_in_ack,
	input  bridge_pkg::host_char_t  host_in,
	output logic                    host_out_req,
	input  logic                    host_out_ack,
	output bridge_pkg::host_char_t  host_out,
	output logic                    mbus_tx_req,
	input  logic                    mbus_tx_ack,
	output mbus_pkg::mbus_tx_word_t mbus_tx,
	input  logic                    mbus_result_req,
	output logic                    mbus_result_ack,
	input  mbus_pkg::tx_result_t    mbus_result,
	input  logic                    mbus_rx_req,
	output logic                    mbus_rx_ack,
	input  mbus_pkg::mbus_rx_word_t mbus_rx
);
	logic                    word_req;
	logic                    word_ack;
	mbus_pkg::mbus_tx_word_t word;
	logic                    reply_req;
	logic                    reply_ack;
	logic [7:0]              reply_eid;
	logic                    reply_succ;
	logic                    rx_req;
	logic                    rx_ack;
	bridge_pkg::host_char_t  rx_chr;
	logic                    out_req;
	logic                    out_ack;
	bridge_pkg::host_char_t  out_chr;

	tx_frame_packer tx_frame_packer_i (
		.clk(clk), .rst(rst),
		.in_req(host_in_req), .in_ack(host_in_ack), .in_char(host_in),
		.word_req(word_req), .word_ack(word_ack), .word(word),
		.result_req(mbus_result_req), .result_ack(mbus_result_ack), .result(mbus_result),
		.reply_req(reply_req), .reply_ack(reply_ack),
		.reply_eid(reply_eid), .reply_succ(reply_succ)
	);

	reqack_slice #(.payload_t(mbus_pkg::mbus_tx_word_t)) tx_slice_i (
		.clk(clk), .rst(rst),
		.in_req(word_req), .in_ack(word_ack), .in_data(word),
		.out_req(mbus_tx_req), .out_ack(mbus_tx_ack), .out_data(mbus_tx)
	);

	rx_word_serializer #(.RX_FLAG(RX_FLAG)) rx_word_serializer_i (
		.clk(clk), .rst(rst),
		.word_req(mbus_rx_req), .word_ack(mbus_rx_ack), .word(mbus_rx),
		.chr_req(rx_req), .chr_ack(rx_ack), .chr(rx_chr)
	);

	reply_merger reply_merger_i (
		.clk(clk), .rst(rst),
		.reply_req(reply_req), .reply_ack(reply_ack),
		.reply_eid(reply_eid), .reply_succ(reply_succ),
		.rx_req(rx_req), .rx_ack(rx_ack), .rx_chr(rx_chr),
		.out_req(out_req), .out_ack(out_ack), .out_chr(out_chr)
	);

	reqack_slice #(.payload_t(bridge_pkg::host_char_t)) out_slice_i (
		.clk(clk), .rst(rst),
		.in_req(out_req), .in_ack(out_ack), .in_data(out_chr),
		.out_req(host_out_req), .out_ack(host_out_ack), .out_data(host_out)
	);

endmodule

// File: tb/mbus_bridge_tb.sv
`timescale 1ns/10ps

module mbus_bridge_tb;
	localparam logic [7:0] RX_FLAG = 8'h62;
	localparam int TIMEOUT = 2000;

	logic clk = 1'b0;
	logic rst;
	logic host_in_req;
	logic host_in_ack;
	bridge_pkg::host_char_t host_in;
	logic host_out_req;
	logic host_out_ack;
	bridge_pkg::host_char_t host_out;
	logic mbus_tx_req;
	logic mbus_tx_ack;
	mbus_pkg::mbus_tx_word_t mbus_tx;
	logic mbus_result_req;
	logic mbus_result_ack;
	mbus_pkg::tx_result_t mbus_result;
	logic mbus_rx_req;
	logic mbus_rx_ack;
	mbus_pkg::mbus_rx_word_t mbus_rx;

	// Current case as read from the data file
	logic [7:0] tx_eid;
	logic [31:0] tx_addr;
	logic tx_succ;
	logic [7:0] tx_flag;
	int tx_n;
	logic [31:0] tx_data [0:7];
	logic [31:0] rx_addr;
	logic [7:0] rx_status;
	int rx_n;
	logic [31:0] rx_data [0:7];
	logic [1:0] rx_flags [0:7];

	// Expected frames in order per source
	logic [15:0] exp_reply [$];
	logic [7:0] exp_rx_bytes [$];
	int exp_rx_len [$];
	logic [7:0] frame [$];
	logic [7:0] exp_seq = 8'd0;
	int errors = 0;
	int timeouts = 0;
	int results_acked = 0;
	int replies_seen = 0;
	logic run_done = 1'b0;

	mbus_bridge #(.RX_FLAG(RX_FLAG)) mbus_bridge_i (
		.clk(clk), .rst(rst),
		.host_in_req(host_in_req), .host_in_ack(host_in_ack), .host_in(host_in),
		.host_out_req(host_out_req), .host_out_ack(host_out_ack), .host_out(host_out),
		.mbus_tx_req(mbus_tx_req), .mbus_tx_ack(mbus_tx_ack), .mbus_tx(mbus_tx),
		.mbus_result_req(mbus_result_req), .mbus_result_ack(mbus_result_ack),
		.mbus_result(mbus_result),
		.mbus_rx_req(mbus_rx_req), .mbus_rx_ack(mbus_rx_ack), .mbus_rx(mbus_rx)
	);

	always #5 clk = ~clk;

	task automatic finish_run;
		$display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout at %0t: %s", $time, what);
		finish_run();
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic send_host_char(input logic [7:0] b, input logic l);
		int cnt;
		idle_cycles($urandom % 3);
		host_in.data = b;
		host_in.last = l;
		host_in_req = 1'b1;
		cnt = 0;
		while (!host_in_ack && cnt < TIMEOUT) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (!host_in_ack)
			report_timeout("host input ack did not rise");
		host_in_req = 1'b0;
		cnt = 0;
		while (host_in_ack && cnt < TIMEOUT) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (host_in_ack)
			report_timeout("host input ack did not fall");
	endtask

	// Event id, address MSB first, then data bytes MSB first
	task automatic send_host_frame;
		int i;
		int k;
		send_host_char(tx_eid, 1'b0);
		for (k = 3; k >= 0; k--)
			send_host_char(tx_addr[8*k +: 8], 1'b0);
		for (i = 0; i < tx_n; i++)
			for (k = 3; k >= 0; k--)
				send_host_char(tx_data[i][8*k +: 8], (i == tx_n - 1) && (k == 0));
	endtask

	task automatic serve_tx_side;
		int i;
		int cnt;
		for (i = 0; i < tx_n; i++) begin
			cnt = 0;
			while (!mbus_tx_req && cnt < TIMEOUT) begin
				@(posedge clk);
				#1;
				cnt++;
			end
			if (!mbus_tx_req) begin
				report_timeout("MBus transmit word never arrived");
			end else begin
				if (mbus_tx.addr !== tx_addr || mbus_tx.data !== tx_data[i] ||
					mbus_tx.pend !== (i != tx_n - 1)) begin
					errors++;
					$display("ERR %0t: tx word %0d is %h/%h/%b, expected %h/%h/%b", $time, i,
						mbus_tx.addr, mbus_tx.data, mbus_tx.pend,
						tx_addr, tx_data[i], i != tx_n - 1);
				end
			end
			idle_cycles($urandom % 4);
			mbus_tx_ack = 1'b1;
			cnt = 0;
			while (mbus_tx_req && cnt < TIMEOUT) begin
				@(posedge clk);
				#1;
				cnt++;
			end
			if (mbus_tx_req)
				report_timeout("MBus transmit req did not fall");
			mbus_tx_ack = 1'b0;
		end
		idle_cycles($urandom % 6);
		mbus_result.succ = tx_succ;
		mbus_result_req = 1'b1;
		cnt = 0;
		while (!mbus_result_ack && cnt < TIMEOUT) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (!mbus_result_ack)
			report_timeout("MBus result ack did not rise");
		mbus_result_req = 1'b0;
		cnt = 0;
		while (mbus_result_ack && cnt < TIMEOUT) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (mbus_result_ack)
			report_timeout("MBus result ack did not fall");
		results_acked++;
	endtask

	task automatic send_rx_message;
		int i;
		int cnt;
		for (i = 0; i < rx_n; i++) begin
			idle_cycles($urandom % 4);
			mbus_rx.addr = rx_addr;
			mbus_rx.data = rx_data[i];
			mbus_rx.pend = (i != rx_n - 1);
			mbus_rx.bcast = rx_flags[i][0];
			mbus_rx.fail = rx_flags[i][1];
			mbus_rx_req = 1'b1;
			cnt = 0;
			while (!mbus_rx_ack && cnt < TIMEOUT) begin
				@(posedge clk);
				#1;
				cnt++;
			end
			if (!mbus_rx_ack)
				report_timeout("MBus receive ack did not rise");
			mbus_rx_req = 1'b0;
			cnt = 0;
			while (mbus_rx_ack && cnt < TIMEOUT) begin
				@(posedge clk);
				#1;
				cnt++;
			end
			if (mbus_rx_ack)
				report_timeout("MBus receive ack did not fall");
		end
	endtask

	task automatic read_tx_fields(input int fd);
		int code;
		int i;
		logic [31:0] v;
		code = $fscanf(fd, "%h %h %h %h %h", tx_eid, tx_addr, tx_succ, tx_flag, tx_n);
		if (code != 5) begin
			errors++;
			$display("Test data transmit fields are incomplete");
		end
		for (i = 0; i < tx_n; i++) begin
			code = $fscanf(fd, "%h", v);
			if (code != 1) begin
				errors++;
				$display("Test data misses transmit word %0d", i);
			end
			tx_data[i] = v;
		end
		if (tx_flag != (tx_succ ? bridge_pkg::ACK_FLAG : bridge_pkg::NAK_FLAG)) begin
			errors++;
			$display("Test data reply flag %h does not match result %0d", tx_flag, tx_succ);
		end
		exp_reply.push_back({tx_flag, tx_eid});
	endtask

	// Flag, sequence, address, data of every word, status
	task automatic read_rx_fields(input int fd);
		int code;
		int i;
		int k;
		logic [31:0] d;
		logic [31:0] f;
		logic [1:0] st;
		code = $fscanf(fd, "%h %h %h", rx_addr, rx_status, rx_n);
		if (code != 3) begin
			errors++;
			$display("Test data receive fields are incomplete");
		end
		st = 2'b00;
		exp_rx_len.push_back(7 + 4 * rx_n);
		exp_rx_bytes.push_back(RX_FLAG);
		exp_rx_bytes.push_back(exp_seq);
		exp_seq = exp_seq + 8'd1;
		for (k = 3; k >= 0; k--)
			exp_rx_bytes.push_back(rx_addr[8*k +: 8]);
		for (i = 0; i < rx_n; i++) begin
			code = $fscanf(fd, "%h %h", d, f);
			if (code != 2) begin
				errors++;
				$display("Test data misses receive word %0d", i);
			end
			rx_data[i] = d;
			rx_flags[i] = f[1:0];
			st = st | f[1:0];
			for (k = 3; k >= 0; k--)
				exp_rx_bytes.push_back(d[8*k +: 8]);
		end
		if (rx_status != {6'd0, st}) begin
			errors++;
			$display("Test data status %h does not match the word flags", rx_status);
		end
		exp_rx_bytes.push_back(rx_status);
	endtask

	task automatic check_frame;
		int i;
		int len;
		logic [15:0] rep;
		logic [7:0] b;
		if (frame[0] == RX_FLAG) begin
			if (exp_rx_len.size() == 0) begin
				errors++;
				$display("Unexpected receive frame at %0t", $time);
			end else begin
				len = exp_rx_len.pop_front();
				if (frame.size() != len) begin
					errors++;
					$display("ERR %0t: receive frame has %0d bytes, expected %0d", $time,
						frame.size(), len);
				end
				for (i = 0; i < len; i++) begin
					b = exp_rx_bytes.pop_front();
					if (i < frame.size() && frame[i] !== b) begin
						errors++;
						$display("ERR %0t: receive byte %0d is %h, expected %h", $time, i,
							frame[i], b);
					end
				end
			end
		end else if (frame[0] == bridge_pkg::ACK_FLAG || frame[0] == bridge_pkg::NAK_FLAG) begin
			if (exp_reply.size() == 0) begin
				errors++;
				$display("Unexpected reply frame at %0t", $time);
			end else begin
				rep = exp_reply.pop_front();
				if (replies_seen >= results_acked) begin
					errors++;
					$display("ERR %0t: reply arrived before its result handshake", $time);
				end
				if (frame.size() != 2 || frame[0] !== rep[15:8] || frame[1] !== rep[7:0]) begin
					errors++;
					$display("ERR %0t: reply frame %h %h, expected %h %h", $time, frame[0],
						frame[1], rep[15:8], rep[7:0]);
				end
				replies_seen++;
			end
		end else begin
			errors++;
			$display("ERR %0t: frame starts with unknown flag %h", $time, frame[0]);
		end
		frame.delete();
	endtask

	task automatic run_all_cases(input int fd);
		logic [63:0] token;
		logic [8*256-1:0] rest;
		int code;
		logic eof_seen;
		eof_seen = 1'b0;
		while (!eof_seen) begin
			code = $fscanf(fd, "%s", token);
			if (code != 1) begin
				eof_seen = 1'b1;
			end else if (token == "#") begin
				code = $fgets(rest, fd);
			end else if (token == "T") begin
				read_tx_fields(fd);
				fork
					send_host_frame();
					serve_tx_side();
				join
			end else if (token == "R") begin
				read_rx_fields(fd);
				send_rx_message();
			end else if (token == "C") begin
				read_tx_fields(fd);
				read_rx_fields(fd);
				fork
					send_host_frame();
					serve_tx_side();
					send_rx_message();
				join
			end else begin
				errors++;
				$display("Test data holds an unknown line kind");
				eof_seen = 1'b1;
			end
		end
	endtask

	task automatic wait_for_drain;
		int cnt;
		cnt = 0;
		while ((exp_reply.size() != 0 || exp_rx_len.size() != 0) && cnt < TIMEOUT) begin
			@(posedge clk);
			#1;
			cnt++;
		end
		if (exp_reply.size() != 0 || exp_rx_len.size() != 0)
			report_timeout("expected output frames never arrived");
	endtask

	// Host side of the output channel with random ack delay
	initial begin : output_monitor
		int cnt;
		bridge_pkg::host_char_t c;
		while (!run_done) begin
			@(posedge clk);
			#1;
			if (host_out_req && !host_out_ack) begin
				idle_cycles($urandom % 5);
				c = host_out;
				host_out_ack = 1'b1;
				frame.push_back(c.data);
				if (c.last)
					check_frame();
				cnt = 0;
				while (host_out_req && cnt < TIMEOUT) begin
					@(posedge clk);
					#1;
					cnt++;
				end
				if (host_out_req)
					report_timeout("host output req did not fall");
				host_out_ack = 1'b0;
			end
		end
	end

	initial begin : main_sequence
		int fd;
		void'($urandom(27));
		rst = 1'b1;
		host_in_req = 1'b0;
		host_in = '0;
		host_out_ack = 1'b0;
		mbus_tx_ack = 1'b0;
		mbus_result_req = 1'b0;
		mbus_result = '0;
		mbus_rx_req = 1'b0;
		mbus_rx = '0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		fd = $fopen("tb/mbus_bridge_testdata.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open tb/mbus_bridge_testdata.txt");
		end else begin
			run_all_cases(fd);
			$fclose(fd);
			wait_for_drain();
			// Leave room for any extra frame to show up
			idle_cycles(50);
		end
		run_done = 1'b1;
		finish_run();
	end

endmodule

// File: mbus_bridge.f
hw/bridge_pkg.sv
hw/mbus_pkg.sv
hw/reqack_slice.sv
hw/tx_frame_packer.sv
hw/rx_word_serializer.sv
hw/reply_merger.sv
hw/mbus_bridge.sv
tb/mbus_bridge_tb.sv

// File: Bender.yml
package:
  name: mbus_bridge

sources:
  - files:
      - hw/bridge_pkg.sv
      - hw/mbus_pkg.sv
      - hw/reqack_slice.sv
      - hw/tx_frame_packer.sv
      - hw/rx_word_serializer.sv
      - hw/reply_merger.sv
      - hw/mbus_bridge.sv
  - target: test
    files:
      - tb/mbus_bridge_tb.sv

// File: tb/mbus_bridge_testdata.txt
# All values hex. T: eid addr succ reply_flag nwords then nwords data words
# R: addr status nwords then data flags per word, flags bit 1 fail bit 0 bcast. C: T fields, R fields
T 11 A0B1C2D3 1 41 1 01234567
T 22 00000010 0 4E 3 DEADBEEF 00000001 FFFFFFFF
R 12345678 00 1 CAFEF00D 0
R 0000AB00 03 3 11111111 0 22222222 2 33333333 1
R 00000F00 01 2 89ABCDEF 1 76543210 0
T 33 FFFFFFFF 1 41 2 00000000 80808080
R 7F000001 02 1 00C0FFEE 2
C 44 00000020 1 41 2 10203040 50607080 01020304 02 2 AABBCCDD 2 EEFF0011 0
C 55 00000030 0 4E 1 5A5A5A5A 00000040 00 1 A5A5A5A5 0
C 66 00000050 1 41 4 01010101 02020202 03030303 04040404 00000060 03 1 F0F0F0F0 3
C 77 00000070 1 41 1 77777777 00000080 01 4 01 1 02 0 03 0 04 0
C 88 00000090 0 4E 2 13579BDF 2468ACE0 000000A0 00 3 0BADF00D 0 FEEDFACE 0 12121212 0
C 99 000000B0 1 41 1 99999999 000000C0 02 2 31415926 0 27182818 2
C AA 000000D0 0 4E 3 00000001 00000002 00000003 000000E0 01 1 ABCDEF01 1
T BB C0DEC0DE 1 41 1 BBBBBBBB
C CC 000000F0 1 41 1 CCCCCCCC 00000100 03 2 DDDDDDDD 1 EEEEEEEE 2
R 00000110 00 1 10101010 0
